//--- sources.f
+incdir+.
ps2LinkPkg.sv
mousePkg.sv
ps2ByteIf.sv
ps2LineSync.sv
ps2FrameReceiver.sv
mousePacketAssembler.sv
mouseTracker.sv
ps2MouseReader.sv
tbPs2MouseReader.sv

//--- run.sh
#!/bin/sh
# Build and run the PS/2 mouse testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sources.f \
    --top-module tbPs2MouseReader --Mdir obj_dir -o simTb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/simTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1

//--- tbPs2MouseReader.sv
`timescale 1ns/1ns
`default_nettype none
`include "ps2_params.svh"

module tbPs2MouseReader;
    import mousePkg::*;

    typedef struct packed
    {
        logic [7:0] byte1;
        logic [7:0] byte2;
        logic [7:0] byte3;
        logic       badParity;  // Applied to byte 3
        logic       badStop;    // Applied to byte 3
        logic       enableLevel;
        logic [1:0] byteCount;  // 1 for a stray byte
    } stimEntry;

    logic CLOCK;
    logic RESET;
    logic ps2Clock;
    logic ps2Data;
    logic enable;
    logic packetValid;
    logic [8*`PS2_PACKET_BYTES-1:0] packetData;
    logic [`MOUSE_POS_WIDTH-1:0] positionX;
    logic [`MOUSE_POS_WIDTH-1:0] positionY;
    logic [2:0] buttons;
    logic linkError;

    stimEntry stimTable[$];
    int errorCount = 0;
    int packetCount = 0;
    int linkErrorCount = 0;
    int cycleCount = 0;
    int cycleLimit = 32'h7fffffff;
    mousePacket lastPacket;
    logic [31:0] rnd = 32'ha96fd892;

    ps2MouseReader dut
    (
        .CLOCK       (CLOCK),
        .RESET       (RESET),
        .ps2Clock    (ps2Clock),
        .ps2Data     (ps2Data),
        .enable      (enable),
        .packetValid (packetValid),
        .packetData  (packetData),
        .positionX   (positionX),
        .positionY   (positionY),
        .buttons     (buttons),
        .linkError   (linkError)
    );

    initial
    begin
        CLOCK = 1'b0;
        forever #50 CLOCK = ~CLOCK;
    end

    always @(posedge CLOCK)
    begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= cycleLimit)
        begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Pulses counted on the falling edge where outputs are settled
    always @(negedge CLOCK)
    begin
        if (packetValid)
        begin
            packetCount <= packetCount + 1;
            lastPacket  <= packetData;
        end
        if (linkError)
            linkErrorCount <= linkErrorCount + 1;
    end

    function automatic logic [31:0] nextRandom(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int clampRange(input int value, input int highest);
        return (value < 0) ? 0 : ((value > highest) ? highest : value);
    endfunction

    function automatic int movement(input logic sign, input logic [7:0] move);
        return sign ? int'(move) - 256 : int'(move);  // 9-bit two's complement
    endfunction

    task automatic addEntry(input logic [7:0] b1, input logic [7:0] b2, input logic [7:0] b3,
                            input logic badP, input logic badS, input logic en,
                            input logic [1:0] count);
        stimTable.push_back({b1, b2, b3, badP, badS, en, count});
    endtask

    task automatic checkPacket(input mousePacket expected, input mousePacket actual);
        if (actual !== expected)
        begin
            errorCount++;
            $display("[ERROR] %0t ns packetData expected %h actual %h",
                     $time, expected, actual);
        end
    endtask

    task automatic checkPosition(input string name, input logic [`MOUSE_POS_WIDTH-1:0] expected,
                                 input logic [`MOUSE_POS_WIDTH-1:0] actual);
        if (actual !== expected)
        begin
            errorCount++;
            $display("[ERROR] %0t ns %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endtask

    task automatic checkButtons(input mouseButtons expected, input mouseButtons actual);
        if (actual !== expected)
        begin
            errorCount++;
            $display("[ERROR] %0t ns buttons expected %b actual %b", $time, expected, actual);
        end
    endtask

    // One 11-bit frame, data set while the mouse clock is high
    task automatic sendByte(input logic [7:0] value, input logic badParity, input logic badStop);
        logic [10:0] frame;
        logic parity;
        int bitIndex;
        parity = ~^value;  // Odd count of ones over data and parity
        frame = {~badStop, parity ^ badParity, value, 1'b0};
        for (bitIndex = 0; bitIndex < 11; bitIndex++)
        begin
            ps2Data = frame[bitIndex];
            repeat (4) @(negedge CLOCK);
            ps2Clock = 1'b0;
            repeat (4) @(negedge CLOCK);
            ps2Clock = 1'b1;
        end
        ps2Data = 1'b1;
        repeat (4) @(negedge CLOCK);
    endtask

    initial
    begin
        stimEntry entry;
        mousePacket expectedPacket;
        mouseButtons modelButtons;
        logic expectPacket;
        logic expectError;
        int modelX;
        int modelY;
        int packetsBefore;
        int errorsBefore;
        int waitCycles;
        int i;
        RESET = 1'b0;
        enable = 1'b1;
        ps2Clock = 1'b1;
        ps2Data = 1'b1;
        modelX = 320;  // Centre of the screen after reset
        modelY = 240;
        modelButtons = '0;

        addEntry(8'h09, 8'h10, 8'h20, 1'b0, 1'b0, 1'b1, 2'd3);
        addEntry(8'h3A, 8'hF0, 8'hE0, 1'b0, 1'b0, 1'b1, 2'd3);
        addEntry(8'hCC, 8'h40, 8'h40, 1'b0, 1'b0, 1'b1, 2'd3);  // Both overflow bits
        addEntry(8'h08, 8'h05, 8'h05, 1'b1, 1'b0, 1'b1, 2'd3);  // Parity error
        addEntry(8'h0A, 8'h03, 8'h02, 1'b0, 1'b0, 1'b1, 2'd3);
        addEntry(8'h09, 8'h07, 8'h07, 1'b0, 1'b1, 1'b1, 2'd3);  // Low stop bit
        addEntry(8'h08, 8'h01, 8'h01, 1'b0, 1'b0, 1'b1, 2'd3);
        addEntry(8'h02, 8'h00, 8'h00, 1'b0, 1'b0, 1'b1, 2'd1);  // Stray byte, bit 3 clear
        addEntry(8'h0C, 8'h11, 8'h22, 1'b0, 1'b0, 1'b1, 2'd3);
        addEntry(8'h08, 8'h20, 8'h20, 1'b0, 1'b0, 1'b0, 2'd3);  // Enable low
        addEntry(8'h09, 8'h30, 8'h30, 1'b0, 1'b0, 1'b0, 2'd3);
        addEntry(8'h0B, 8'h04, 8'h08, 1'b0, 1'b0, 1'b1, 2'd3);
        for (i = 0; i < 4; i++)
            addEntry(8'h08, 8'h7F, 8'h7F, 1'b0, 1'b0, 1'b1, 2'd3);  // Push to right and top
        for (i = 0; i < 6; i++)
            addEntry(8'h38, 8'h80, 8'h80, 1'b0, 1'b0, 1'b1, 2'd3);  // Push to left and bottom
        for (i = 0; i < 8; i++)
        begin
            rnd = nextRandom(rnd);
            addEntry({2'b00, rnd[9:8], 1'b1, rnd[2:0]}, rnd[23:16], rnd[31:24],
                     1'b0, 1'b0, 1'b1, 2'd3);
        end
        cycleLimit = stimTable.size() * 3 * 11 * 8 * 2;

        repeat (2) @(negedge CLOCK);
        RESET = 1'b1;
        @(negedge CLOCK);
        if (packetValid !== 1'b0 || linkError !== 1'b0)
        begin
            errorCount++;
            $display("Strobe outputs are not low after reset");
        end
        checkPosition("positionX", 10'd320, positionX);
        checkPosition("positionY", 10'd240, positionY);
        checkButtons('0, mouseButtons'(buttons));

        foreach (stimTable[n])
        begin
            entry = stimTable[n];
            enable = entry.enableLevel;
            repeat (4) @(negedge CLOCK);
            packetsBefore = packetCount;
            errorsBefore = linkErrorCount;
            expectError = entry.enableLevel & (entry.badParity | entry.badStop);
            expectPacket = entry.enableLevel & ~entry.badParity & ~entry.badStop
                         & (entry.byteCount == 2'd3) & entry.byte1[3];
            sendByte(entry.byte1, 1'b0, 1'b0);
            if (entry.byteCount == 2'd3)
            begin
                sendByte(entry.byte2, 1'b0, 1'b0);
                sendByte(entry.byte3, entry.badParity, entry.badStop);
            end
            waitCycles = 0;
            while (waitCycles < 20 && packetCount == packetsBefore
                   && linkErrorCount == errorsBefore)
            begin
                @(negedge CLOCK);
                waitCycles++;
            end
            repeat (3) @(negedge CLOCK);  // Tracker update and any extra pulse

            if (packetCount - packetsBefore != (expectPacket ? 1 : 0))
            begin
                errorCount++;
                $display("Entry %0d: expected %0d packetValid pulse(s) but saw %0d",
                         n, expectPacket, packetCount - packetsBefore);
            end
            if (linkErrorCount - errorsBefore != (expectError ? 1 : 0))
            begin
                errorCount++;
                $display("Entry %0d: expected %0d linkError pulse(s) but saw %0d",
                         n, expectError, linkErrorCount - errorsBefore);
            end
            if (expectPacket)
            begin
                expectedPacket = {entry.byte3, entry.byte2, entry.byte1};
                checkPacket(expectedPacket, lastPacket);
                if (!entry.byte1[6])
                    modelX = clampRange(modelX + movement(entry.byte1[4], entry.byte2),
                                        `MOUSE_X_MAX);
                if (!entry.byte1[7])
                    modelY = clampRange(modelY - movement(entry.byte1[5], entry.byte3),
                                        `MOUSE_Y_MAX);
                modelButtons = entry.byte1[2:0];
            end
            checkPosition("positionX", modelX[`MOUSE_POS_WIDTH-1:0], positionX);
            checkPosition("positionY", modelY[`MOUSE_POS_WIDTH-1:0], positionY);
            checkButtons(modelButtons, mouseButtons'(buttons));
        end

        $display("Checks done with %0d error(s)", errorCount);
        if (errorCount == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- ps2MouseReader.sv
`timescale 1ns/1ns
`default_nettype none
`include "ps2_params.svh"

module ps2MouseReader
(
    input  wire                                CLOCK,
    input  wire                                RESET,
    input  wire                                ps2Clock,
    input  wire                                ps2Data,
    input  wire                                enable,
    output logic                               packetValid,
    output logic [8*`PS2_PACKET_BYTES-1:0]     packetData,
    output logic [`MOUSE_POS_WIDTH-1:0]        positionX,
    output logic [`MOUSE_POS_WIDTH-1:0]        positionY,
    output logic [2:0]                         buttons,
    output logic                               linkError
);
    import mousePkg::*;

    logic       fallEdge;
    logic       dataBit;
    logic       lineIdle;
    mousePacket packetWord;

    ps2ByteIf byteLink ();  // Receiver to assembler

    ps2LineSync lineSync
    (
        .CLOCK    (CLOCK),
        .RESET    (RESET),
        .ps2Clock (ps2Clock),
        .ps2Data  (ps2Data),
        .fallEdge (fallEdge),
        .dataBit  (dataBit),
        .lineIdle (lineIdle)
    );

    ps2FrameReceiver frameReceiver
    (
        .CLOCK    (CLOCK),
        .RESET    (RESET),
        .enable   (enable),
        .fallEdge (fallEdge),
        .dataBit  (dataBit),
        .lineIdle (lineIdle),
        .byteOut  (byteLink.receiver)
    );

    mousePacketAssembler packetAssembler
    (
        .CLOCK       (CLOCK),
        .RESET       (RESET),
        .enable      (enable),
        .byteIn      (byteLink.assembler),
        .packetValid (packetValid),
        .packet      (packetWord),
        .linkError   (linkError)
    );

    mouseTracker tracker
    (
        .CLOCK       (CLOCK),
        .RESET       (RESET),
        .packetValid (packetValid),
        .packet      (packetWord),
        .positionX   (positionX),
        .positionY   (positionY),
        .buttons     (buttons)
    );

    assign packetData = packetWord;  // Flattened, byte 1 in bits 7:0

endmodule

`default_nettype wire

//--- mouseTracker.sv
`timescale 1ns/1ns
`default_nettype none
`include "ps2_params.svh"

module mouseTracker
(
    input  wire                          CLOCK,
    input  wire                          RESET,
    input  wire                          packetValid,
    input  wire mousePkg::mousePacket    packet,
    output logic [`MOUSE_POS_WIDTH-1:0]  positionX,
    output logic [`MOUSE_POS_WIDTH-1:0]  positionY,
    output mousePkg::mouseButtons        buttons
);

    localparam int PosWidth = `MOUSE_POS_WIDTH;
    localparam logic [PosWidth-1:0] MaxX = `MOUSE_X_MAX;
    localparam logic [PosWidth-1:0] MaxY = `MOUSE_Y_MAX;
    localparam logic [PosWidth-1:0] CentreX = (`MOUSE_X_MAX + 1) / 2;
    localparam logic [PosWidth-1:0] CentreY = (`MOUSE_Y_MAX + 1) / 2;

    logic signed [PosWidth+1:0] deltaX;  // Two spare bits for sign and carry
    logic signed [PosWidth+1:0] deltaY;
    logic signed [PosWidth+1:0] sumX;
    logic signed [PosWidth+1:0] sumY;

    function automatic logic [PosWidth-1:0] clampCoord
    (
        input logic signed [PosWidth+1:0] value,
        input logic [PosWidth-1:0]        limit
    );
        if (value < 0)
            return '0;
        else if (value > $signed({2'b00, limit}))
            return limit;
        else
            return value[PosWidth-1:0];
    endfunction

    // 9-bit two's complement movement, dropped on overflow
    assign deltaX = packet.xOverflow ? 9'sd0 : $signed({packet.xSign, packet.xMove});
    assign deltaY = packet.yOverflow ? 9'sd0 : $signed({packet.ySign, packet.yMove});

    assign sumX = $signed({2'b00, positionX}) + deltaX;
    assign sumY = $signed({2'b00, positionY}) - deltaY;  // PS/2 up is screen row down

    always_ff @(posedge CLOCK or negedge RESET)
    begin
        if (!RESET)
        begin
            positionX <= CentreX;
            positionY <= CentreY;
            buttons   <= '0;
        end
        else if (packetValid)
        begin
            positionX <= clampCoord(sumX, MaxX);
            positionY <= clampCoord(sumY, MaxY);
            buttons   <= {packet.middle, packet.right, packet.left};
        end
    end

endmodule

`default_nettype wire

//--- mousePacketAssembler.sv
`timescale 1ns/1ns
`default_nettype none
`include "ps2_params.svh"

module mousePacketAssembler
(
    input  wire                 CLOCK,
    input  wire                 RESET,
    input  wire                 enable,
    ps2ByteIf.assembler         byteIn,
    output logic                packetValid,
    output mousePkg::mousePacket packet,
    output logic                linkError
);
    import mousePkg::*;

    assemblerState state;
    logic [8*(`PS2_PACKET_BYTES-1)-1:0] heldBytes;  // Earlier bytes, byte 1 lowest
    logic byteClean;
    logic storeByte;

    assign byteClean = byteIn.byteValid & ~byteIn.parityError & ~byteIn.frameError;

    // Bytes 1 and 2 shift in from the top; a first byte without bit 3 is skipped
    assign storeByte = enable & byteClean & (state != thirdByte)
                     & ((state != firstByte) | byteIn.byteData[3]);

    always_ff @(posedge CLOCK)
    begin
        if (storeByte)
            heldBytes <= {byteIn.byteData, heldBytes[8*(`PS2_PACKET_BYTES-1)-1:8]};
    end

    always_ff @(posedge CLOCK or negedge RESET)
    begin
        if (!RESET)
        begin
            state       <= firstByte;
            packetValid <= 1'b0;
            linkError   <= 1'b0;
            packet      <= '0;
        end
        else
        begin
            packetValid <= 1'b0;
            linkError   <= 1'b0;
            if (!enable)
                state <= firstByte;  // Drop a partial packet
            else if (byteIn.byteValid)
            begin
                if (!byteClean)
                begin
                    linkError <= 1'b1;
                    state     <= firstByte;  // Resync on the next good byte 1
                end
                else
                begin
                    case (state)
                        firstByte:
                        begin
                            if (byteIn.byteData[3])
                                state <= secondByte;  // Otherwise stay to re-align
                        end
                        secondByte:
                            state <= thirdByte;
                        thirdByte:
                        begin
                            packet      <= {byteIn.byteData, heldBytes};
                            packetValid <= 1'b1;
                            state       <= firstByte;
                        end
                        default:
                            state <= firstByte;
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- ps2FrameReceiver.sv
`timescale 1ns/1ns
`default_nettype none

module ps2FrameReceiver
(
    input  wire        CLOCK,
    input  wire        RESET,
    input  wire        enable,
    input  wire        fallEdge,
    input  wire        dataBit,
    input  wire        lineIdle,
    ps2ByteIf.receiver byteOut
);
    import ps2LinkPkg::*;

    frameState  state;
    logic [2:0] bitCount;
    ps2Byte     shiftReg;
    logic       parityBad;
    logic       armed;  // Line seen idle since enable rose

    always_ff @(posedge CLOCK or negedge RESET)
    begin
        if (!RESET)
        begin
            state               <= idle;
            bitCount            <= 3'd0;
            shiftReg            <= '0;
            parityBad           <= 1'b0;
            armed               <= 1'b0;
            byteOut.byteValid   <= 1'b0;
            byteOut.byteData    <= '0;
            byteOut.parityError <= 1'b0;
            byteOut.frameError  <= 1'b0;
        end
        else
        begin
            byteOut.byteValid <= 1'b0;
            if (!enable)
            begin
                state <= idle;  // Drop any partial frame
                armed <= 1'b0;
            end
            else
            begin
                if (lineIdle)
                    armed <= 1'b1;
                if (fallEdge)
                begin
                    case (state)
                        idle:
                        begin
                            if (armed && !dataBit)  // Low start bit only
                            begin
                                state    <= dataBits;
                                bitCount <= 3'd0;
                            end
                        end
                        dataBits:
                        begin
                            shiftReg <= {dataBit, shiftReg[7:1]};  // LSB arrives first
                            bitCount <= bitCount + 3'd1;
                            if (bitCount == 3'd7)
                                state <= parityBit;
                        end
                        parityBit:
                        begin
                            // Data plus parity must hold an odd count of ones
                            parityBad <= ~(^{dataBit, shiftReg});
                            state     <= stopBit;
                        end
                        stopBit:
                        begin
                            byteOut.byteValid   <= 1'b1;  // Published even on error
                            byteOut.byteData    <= shiftReg;
                            byteOut.parityError <= parityBad;
                            byteOut.frameError  <= ~dataBit;
                            state               <= idle;
                        end
                        default:
                            state <= idle;
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- ps2LineSync.sv
`timescale 1ns/1ns
`default_nettype none

module ps2LineSync
(
    input  wire  CLOCK,
    input  wire  RESET,
    input  wire  ps2Clock,
    input  wire  ps2Data,
    output logic fallEdge,
    output logic dataBit,
    output logic lineIdle
);

    logic [1:0] clockSync;  // Bit 1 is the settled value
    logic [1:0] dataSync;
    logic       clockPrev;

    always_ff @(posedge CLOCK or negedge RESET)
    begin
        if (!RESET)
        begin
            clockSync <= 2'b11;  // Lines idle high
            dataSync  <= 2'b11;
            clockPrev <= 1'b1;
            fallEdge  <= 1'b0;
            dataBit   <= 1'b1;
        end
        else
        begin
            clockSync <= {clockSync[0], ps2Clock};
            dataSync  <= {dataSync[0], ps2Data};
            clockPrev <= clockSync[1];
            fallEdge  <= clockPrev & ~clockSync[1];  // High-to-low on settled clock
            dataBit   <= dataSync[1];                // Aligned with fallEdge
        end
    end

    assign lineIdle = clockSync[1] & dataSync[1];

endmodule

`default_nettype wire

//--- ps2ByteIf.sv
`timescale 1ns/1ns
`default_nettype none

interface ps2ByteIf;
    import ps2LinkPkg::*;

    logic   byteValid;    // One-cycle strobe
    ps2Byte byteData;
    logic   parityError;  // Only meaningful with byteValid
    logic   frameError;   // Stop bit was low

    modport receiver (output byteValid, output byteData, output parityError, output frameError);
    modport assembler (input byteValid, input byteData, input parityError, input frameError);

endinterface

`default_nettype wire

//--- mousePkg.sv
`default_nettype none

package mousePkg;

    // Byte 1 in bits 7:0, Y movement on top
    typedef struct packed
    {
        logic [7:0] yMove;
        logic [7:0] xMove;
        logic       yOverflow;
        logic       xOverflow;
        logic       ySign;
        logic       xSign;
        logic       alwaysOne;  // Used for packet alignment
        logic       middle;
        logic       right;
        logic       left;
    } mousePacket;

    // Same bit order as the low three bits of byte 1
    typedef struct packed
    {
        logic middle;
        logic right;
        logic left;
    } mouseButtons;

    typedef enum logic [1:0]
    {
        firstByte,
        secondByte,
        thirdByte
    } assemblerState;

endpackage

`default_nettype wire

//--- ps2LinkPkg.sv
`default_nettype none

package ps2LinkPkg;

    // One data byte off the serial link
    typedef logic [7:0] ps2Byte;

    // Position inside an 11-bit frame
    typedef enum logic [1:0]
    {
        idle,       // Waiting for start bit
        dataBits,   // Eight bits, LSB first
        parityBit,  // Odd parity
        stopBit     // Expected high
    } frameState;

endpackage

`default_nettype wire

//--- ps2_params.svh
`ifndef PS2_PARAMS_SVH
`define PS2_PARAMS_SVH

// Standard three-byte mouse packet, no scroll wheel
`define PS2_PACKET_BYTES 3

// Coordinate width, wide enough for 0..639
`define MOUSE_POS_WIDTH 10

// Screen area limits, lowest coordinate is 0
`define MOUSE_X_MAX 639
`define MOUSE_Y_MAX 479

`endif
